//--- build.f
card_pkg.sv
bus_cycle_decoder.sv
wait_state_gen.sv
interrupt_timer.sv
io_register_file.sv
io_test_card.sv
tb_io_test_card.sv

//--- bus_cycle_decoder.sv
//////////////////////////////////////////////////
// Bus cycle decoder
// Qualifies page strobes, registers per-register requests
//////////////////////////////////////////////////

`timescale 1ns/1ns

module bus_cycle_decoder (
   input  logic                        nw,         // Card clock
   input  logic                        arst_n,     // Async reset, active low
   input  logic                        io_sel,     // Page select
   input  logic [card_pkg::ADDR_W-1:0] addr,       // Page offset
   input  logic [card_pkg::DATA_W-1:0] wdata,      // Write word
   input  logic                        wr_stb,     // Write strobe
   input  logic                        rd_stb,     // Read strobe
   input  logic                        ws,         // Wait state running
   output logic                        wr_port_a,  // Write operand A
   output logic                        wr_port_b,  // Write operand B
   output logic                        wr_timer,   // Write timer count
   output logic [card_pkg::DATA_W-1:0] load_data,  // Captured write word
   output logic                        rd_req,     // Read request
   output logic [card_pkg::ADDR_W-1:0] rd_ofs,     // Captured read offset
   output logic                        ws_start    // F0 touched, start the wait
);

   logic acc_ok;                                   // Access qualifies
   logic wr_acc;                                   // Accepted write
   logic rd_acc;                                   // Accepted read

   // Only the F0..FF span answers, and nothing while a wait runs
   assign acc_ok = io_sel && (addr >= card_pkg::OFS_WAIT) && !ws;
   assign wr_acc = acc_ok && wr_stb;
   assign rd_acc = acc_ok && rd_stb;

   // Unregistered so the wait shows up on the next edge
   assign ws_start = (wr_acc || rd_acc) && (addr == card_pkg::OFS_WAIT);

   //////////////////////////////////////////////////
   // Request strobes
   always_ff @(posedge nw or negedge arst_n) begin
      if (!arst_n) begin
         wr_port_a <= 1'b0;
         wr_port_b <= 1'b0;
         wr_timer  <= 1'b0;
         rd_req    <= 1'b0;
      end else begin
         wr_port_a <= wr_acc && (addr == card_pkg::OFS_PORT_A); // One-hot writes
         wr_port_b <= wr_acc && (addr == card_pkg::OFS_PORT_B);
         wr_timer  <= wr_acc && (addr == card_pkg::OFS_TIMER);
         rd_req    <= rd_acc;                      // Every accepted read
      end
   end

   // Payload capture
   always_ff @(posedge nw) begin
      if (wr_acc)
         load_data <= wdata;                       // Held until the next write
      if (rd_acc)
         rd_ofs <= addr;                           // Held until the next read
   end

endmodule

//--- card_pkg.sv
//////////////////////////////////////////////////
// I/O test card shared definitions
// Bus widths, page offsets, readback words, timing
//////////////////////////////////////////////////

package card_pkg;

   //////////////////////////////////////////////////
   // Bus widths
   localparam int ADDR_W = 8;                      // Page offset
   localparam int DATA_W = 16;                     // Data word

   //////////////////////////////////////////////////
   // Register offsets in the upper page
   localparam logic [ADDR_W-1:0] OFS_WAIT    = 8'hf0; // Wait-state register
   localparam logic [ADDR_W-1:0] OFS_ZERO_LO = 8'hf1; // First zero word
   localparam logic [ADDR_W-1:0] OFS_ZERO_HI = 8'hf7; // Last zero word
   localparam logic [ADDR_W-1:0] OFS_CONST_LO = 8'hf8; // First constant
   localparam logic [ADDR_W-1:0] OFS_CONST_HI = 8'hfc; // Last constant
   localparam logic [ADDR_W-1:0] OFS_PORT_A  = 8'hfd; // Operand A
   localparam logic [ADDR_W-1:0] OFS_PORT_B  = 8'hfe; // Operand B, skip source
   localparam logic [ADDR_W-1:0] OFS_TIMER   = 8'hff; // Countdown timer

   //////////////////////////////////////////////////
   // Readback words
   // Entry 0 answers F8, entry 4 answers FC
   localparam logic [4:0][DATA_W-1:0] CONST_TABLE = {
      16'h4321,                                    // FC
      16'hdef0,                                    // FB
      16'h9abc,                                    // FA
      16'h5678,                                    // F9
      16'h1234                                     // F8
   };
   localparam logic [DATA_W-1:0] WAIT_DATA = 16'h5501; // F0 after the wait

   //////////////////////////////////////////////////
   // Timing counts
   localparam int WS_CYCLES = 5;                   // Cycles of ws per F0 access
   localparam int WS_W      = $clog2(WS_CYCLES + 1); // Wait counter width
   localparam int TICK_DIV  = 7;                   // Clocks per timer decrement
   localparam int TICK_W    = $clog2(TICK_DIV);    // Prescaler width

endpackage

//--- interrupt_timer.sv
//////////////////////////////////////////////////
// Interrupt timer
// Prescaled countdown, irq on expiry
//////////////////////////////////////////////////

`timescale 1ns/1ns

module interrupt_timer (
   input  logic                        nw,         // Card clock
   input  logic                        arst_n,     // Async reset, active low
   input  logic                        wr_timer,   // Write to FF
   input  logic [card_pkg::DATA_W-1:0] load_data,  // New count
   output logic [card_pkg::DATA_W-1:0] count,      // Live count
   output logic                        irq         // Expired level
);

   logic [card_pkg::TICK_W-1:0] presc;             // Tick divider
   logic                        tick;              // Decrement this cycle
   logic                        en;                // Countdown running

   assign tick = (presc == card_pkg::TICK_W'(card_pkg::TICK_DIV - 1));

   //////////////////////////////////////////////////
   // Load, decrement and expiry
   always_ff @(posedge nw or negedge arst_n) begin
      if (!arst_n) begin
         presc <= '0;
         count <= '0;
         en    <= 1'b0;
         irq   <= 1'b0;
      end else if (wr_timer) begin
         count <= load_data;                       // Zero stops the timer
         en    <= (load_data != '0);
         irq   <= 1'b0;                            // Any write acknowledges
         presc <= '0;                              // Full first period
      end else if (en) begin
         presc <= tick ? '0 : presc + 1'b1;
         if (tick) begin
            count <= count - 1'b1;
            if (count == card_pkg::DATA_W'(1)) begin
               en  <= 1'b0;                        // Stop at zero
               irq <= 1'b1;                        // Held until the next write
            end
         end
      end
   end

endmodule

//--- io_register_file.sv
//////////////////////////////////////////////////
// I/O register file
// Operand ports, product, readback mux, skip flag
//////////////////////////////////////////////////

`timescale 1ns/1ns

module io_register_file (
   input  logic                        nw,         // Card clock
   input  logic                        arst_n,     // Async reset, active low
   input  logic                        wr_port_a,  // Write operand A
   input  logic                        wr_port_b,  // Write operand B
   input  logic [card_pkg::DATA_W-1:0] load_data,  // Write word
   input  logic                        rd_req,     // Read request
   input  logic [card_pkg::ADDR_W-1:0] rd_ofs,     // Read offset
   input  logic                        ws_done,    // Wait finished
   input  logic [card_pkg::DATA_W-1:0] count,      // Live timer count
   output logic [card_pkg::DATA_W-1:0] rdata,      // Read word
   output logic                        rd_valid,   // Read answer strobe
   output logic                        skip        // Zero product flag
);

   logic [card_pkg::DATA_W-1:0] port_a;            // Operand A
   logic [card_pkg::DATA_W-1:0] port_b;            // Operand B
   logic [card_pkg::DATA_W-1:0] product;           // Low half of A*B
   logic [card_pkg::DATA_W-1:0] rd_word;           // Mux output
   logic [2:0]                  const_idx;         // Constant table entry
   logic                        is_prod;           // Offset FD or FE
   logic                        is_wait;           // Offset F0
   logic                        rd_pend;           // F0 read waiting on ws_done

   assign product = port_a * port_b;               // Truncated to 16 bits
   assign is_prod = (rd_ofs == card_pkg::OFS_PORT_A) || (rd_ofs == card_pkg::OFS_PORT_B);
   assign is_wait = (rd_ofs == card_pkg::OFS_WAIT);

   //////////////////////////////////////////////////
   // Read mux
   always_comb begin
      const_idx = 3'(rd_ofs - card_pkg::OFS_CONST_LO);
      case (rd_ofs) inside
         [card_pkg::OFS_ZERO_LO:card_pkg::OFS_ZERO_HI]:
            rd_word = '0;                          // Unused words read zero
         [card_pkg::OFS_CONST_LO:card_pkg::OFS_CONST_HI]:
            rd_word = card_pkg::CONST_TABLE[const_idx];
         card_pkg::OFS_PORT_A, card_pkg::OFS_PORT_B:
            rd_word = product;                     // Both ports read the product
         card_pkg::OFS_TIMER:
            rd_word = count;
         default:
            rd_word = '0;                          // F0 answers later
      endcase
   end

   //////////////////////////////////////////////////
   // Ports and read answer
   always_ff @(posedge nw or negedge arst_n) begin
      if (!arst_n) begin
         port_a   <= '0;
         port_b   <= '0;
         rdata    <= '0;
         rd_valid <= 1'b0;
         skip     <= 1'b0;
         rd_pend  <= 1'b0;
      end else begin
         if (wr_port_a)
            port_a <= load_data;
         if (wr_port_b)
            port_b <= load_data;

         rd_valid <= 1'b0;                         // Single-cycle strobe
         skip     <= 1'b0;

         if (rd_req && is_wait) begin
            rd_pend <= 1'b1;                       // Park until the wait ends
         end else if (rd_req) begin
            rd_valid <= 1'b1;
            rdata    <= rd_word;
            skip     <= is_prod && (product == '0); // Skip on a zero product
         end

         // Accesses are blocked during ws so this never meets rd_req
         if (ws_done && rd_pend) begin
            rd_pend  <= 1'b0;
            rd_valid <= 1'b1;
            rdata    <= card_pkg::WAIT_DATA;
         end
      end
   end

endmodule

//--- io_test_card.sv
//////////////////////////////////////////////////
// I/O test card top level
// Decoder, register file, timer and wait-state block
//////////////////////////////////////////////////

`timescale 1ns/1ns

module io_test_card (
   input  logic                        nw,         // Card clock
   input  logic                        arst_n,     // Async reset, active low
   input  logic                        io_sel,     // Page select
   input  logic [card_pkg::ADDR_W-1:0] addr,       // Page offset
   input  logic [card_pkg::DATA_W-1:0] wdata,      // Write word
   input  logic                        wr_stb,     // Write strobe
   input  logic                        rd_stb,     // Read strobe
   output logic [card_pkg::DATA_W-1:0] rdata,      // Read word
   output logic                        rd_valid,   // Read answer strobe
   output logic                        skip,       // Zero product flag
   output logic                        ws,         // Wait-state level
   output logic                        irq         // Interrupt level
);

   logic                        wr_port_a;         // Decoder to register file
   logic                        wr_port_b;
   logic                        wr_timer;          // Decoder to timer
   logic [card_pkg::DATA_W-1:0] load_data;         // Shared write payload
   logic                        rd_req;
   logic [card_pkg::ADDR_W-1:0] rd_ofs;
   logic                        ws_start;          // Decoder to wait block
   logic                        ws_done;           // Wait block to register file
   logic [card_pkg::DATA_W-1:0] count;             // Timer to register file

   //////////////////////////////////////////////////
   // Producer
   bus_cycle_decoder u_dec (
      .nw        (nw),
      .arst_n    (arst_n),
      .io_sel    (io_sel),
      .addr      (addr),
      .wdata     (wdata),
      .wr_stb    (wr_stb),
      .rd_stb    (rd_stb),
      .ws        (ws),
      .wr_port_a (wr_port_a),
      .wr_port_b (wr_port_b),
      .wr_timer  (wr_timer),
      .load_data (load_data),
      .rd_req    (rd_req),
      .rd_ofs    (rd_ofs),
      .ws_start  (ws_start)
   );

   // Wait states for F0
   wait_state_gen u_ws (
      .nw       (nw),
      .arst_n   (arst_n),
      .ws_start (ws_start),
      .ws       (ws),
      .ws_done  (ws_done)
   );

   //////////////////////////////////////////////////
   // Buffer and consumer
   io_register_file u_regs (
      .nw        (nw),
      .arst_n    (arst_n),
      .wr_port_a (wr_port_a),
      .wr_port_b (wr_port_b),
      .load_data (load_data),
      .rd_req    (rd_req),
      .rd_ofs    (rd_ofs),
      .ws_done   (ws_done),
      .count     (count),
      .rdata     (rdata),
      .rd_valid  (rd_valid),
      .skip      (skip)
   );

   interrupt_timer u_timer (
      .nw        (nw),
      .arst_n    (arst_n),
      .wr_timer  (wr_timer),
      .load_data (load_data),
      .count     (count),
      .irq       (irq)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile the I/O test card testbench with Verilator and run it
verilator --binary --timing --assert --timescale 1ns/1ns \
   -f build.f --top-module tb_io_test_card -o sim_io_test_card \
   && ./obj_dir/sim_io_test_card | tee /dev/stderr | grep -F "PASS: all tests" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

//--- tb_io_test_card.sv
//////////////////////////////////////////////////
// I/O test card testbench
// Cycle reference model checked by concurrent assertions
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_io_test_card;

   logic        nw;                                // Card clock
   logic        arst_n;                            // Async reset, active low
   logic        io_sel;
   logic [7:0]  addr;
   logic [15:0] wdata;
   logic        wr_stb;
   logic        rd_stb;
   logic [15:0] rdata;
   logic        rd_valid;
   logic        skip;
   logic        ws;
   logic        irq;

   //////////////////////////////////////////////////
   // Reference model state
   int          cyc;                               // Edges since reset
   int          ws_left;                           // Expected wait cycles left
   logic        f0_pend;                           // F0 read awaiting its answer
   int          f0_due;                            // Edge that answers the F0 read
   logic        q_rd;                              // Accepted read, one edge old
   logic [7:0]  q_ofs;
   logic        q_wr_a;                            // Accepted writes, one edge old
   logic        q_wr_b;
   logic        q_wr_t;
   logic [15:0] q_data;
   logic [15:0] m_a;                               // Expected operand ports
   logic [15:0] m_b;
   logic [15:0] m_count;                           // Expected timer
   logic        m_en;
   logic        m_irq;
   int          m_ticks;
   logic        exp_valid;                         // Expected outputs after each edge
   logic [15:0] exp_data;
   logic        exp_skip;
   logic        accept;                            // Strobe would be taken this edge

   io_test_card UUT (
      .nw       (nw),
      .arst_n   (arst_n),
      .io_sel   (io_sel),
      .addr     (addr),
      .wdata    (wdata),
      .wr_stb   (wr_stb),
      .rd_stb   (rd_stb),
      .rdata    (rdata),
      .rd_valid (rd_valid),
      .skip     (skip),
      .ws       (ws),
      .irq      (irq)
   );

   initial begin
      nw = 1'b0;
      forever #10 nw = ~nw;                        // 20 ns period
   end

   task automatic stop_run(input string line);
      $display("%s", line);
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped");
   endtask

   task automatic value_error(input string msg);
      stop_run($sformatf("error %0t: %s", $time, msg));
   endtask

   function automatic logic [15:0] low_product(input logic [15:0] a, input logic [15:0] b);
      logic [31:0] full;
      full = {16'h0000, a} * {16'h0000, b};
      return full[15:0];                           // Card keeps the low half
   endfunction

   function automatic logic [15:0] expected_word(input logic [7:0] ofs);
      case (ofs)
         8'hf8:        return 16'h1234;
         8'hf9:        return 16'h5678;
         8'hfa:        return 16'h9abc;
         8'hfb:        return 16'hdef0;
         8'hfc:        return 16'h4321;
         8'hfd, 8'hfe: return low_product(m_a, m_b);
         8'hff:        return m_count;
         default:      return 16'h0000;            // F1 to F7
      endcase
   endfunction

   //////////////////////////////////////////////////
   // Reference model, one step per rising edge
   assign accept = io_sel && (addr >= 8'hf0) && (ws_left == 0);

   always @(posedge nw or negedge arst_n) begin
      if (!arst_n) begin
         cyc       <= 0;
         ws_left   <= 0;
         f0_pend   <= 1'b0;
         f0_due    <= 0;
         q_rd      <= 1'b0;
         q_ofs     <= 8'h00;
         q_wr_a    <= 1'b0;
         q_wr_b    <= 1'b0;
         q_wr_t    <= 1'b0;
         q_data    <= 16'h0000;
         m_a       <= 16'h0000;
         m_b       <= 16'h0000;
         m_count   <= 16'h0000;
         m_en      <= 1'b0;
         m_irq     <= 1'b0;
         m_ticks   <= 0;
         exp_valid <= 1'b0;
         exp_data  <= 16'h0000;
         exp_skip  <= 1'b0;
      end else begin
         cyc       <= cyc + 1;
         exp_valid <= q_rd || (f0_pend && (cyc == f0_due)); // Answers due now
         exp_skip  <= q_rd && ((q_ofs == 8'hfd) || (q_ofs == 8'hfe))
                      && (low_product(m_a, m_b) == 16'h0000);
         if (q_rd) begin
            exp_data <= expected_word(q_ofs);
         end else if (f0_pend && (cyc == f0_due)) begin
            exp_data <= 16'h5501;                  // F0 word after the wait
            f0_pend  <= 1'b0;
         end
         if (q_wr_a)
            m_a <= q_data;
         if (q_wr_b)
            m_b <= q_data;
         if (q_wr_t) begin
            m_count <= q_data;                     // Zero leaves it stopped
            m_en    <= (q_data != 16'h0000);
            m_irq   <= 1'b0;
            m_ticks <= 0;
         end else if (m_en) begin
            if (m_ticks == card_pkg::TICK_DIV - 1) begin
               m_ticks <= 0;
               m_count <= m_count - 16'd1;
               if (m_count == 16'd1) begin
                  m_en  <= 1'b0;
                  m_irq <= 1'b1;                   // Expiry
               end
            end else begin
               m_ticks <= m_ticks + 1;
            end
         end
         q_rd   <= accept && rd_stb && (addr != 8'hf0);
         q_ofs  <= addr;
         q_wr_a <= accept && wr_stb && (addr == 8'hfd);
         q_wr_b <= accept && wr_stb && (addr == 8'hfe);
         q_wr_t <= accept && wr_stb && (addr == 8'hff);
         q_data <= wdata;
         if (accept && (rd_stb || wr_stb) && (addr == 8'hf0))
            ws_left <= card_pkg::WS_CYCLES;        // Any F0 access waits
         else if (ws_left != 0)
            ws_left <= ws_left - 1;
         if (accept && rd_stb && (addr == 8'hf0)) begin
            f0_pend <= 1'b1;
            f0_due  <= cyc + card_pkg::WS_CYCLES;
         end
      end
   end

   //////////////////////////////////////////////////
   // Checks against the model
   valid_check: assert property (@(posedge nw) disable iff (!arst_n) rd_valid == exp_valid)
      else value_error($sformatf("rd_valid %0b, expected %0b", rd_valid, exp_valid));
   data_check: assert property (@(posedge nw) disable iff (!arst_n)
      exp_valid |-> (rdata == exp_data))
      else value_error($sformatf("rdata %h, expected %h", rdata, exp_data));
   skip_check: assert property (@(posedge nw) disable iff (!arst_n) skip == exp_skip)
      else value_error($sformatf("skip %0b, expected %0b", skip, exp_skip));
   ws_check: assert property (@(posedge nw) disable iff (!arst_n) ws == (ws_left != 0))
      else value_error($sformatf("ws %0b, expected %0b", ws, ws_left != 0));
   irq_check: assert property (@(posedge nw) disable iff (!arst_n) irq == m_irq)
      else value_error($sformatf("irq %0b, expected %0b", irq, m_irq));

   //////////////////////////////////////////////////
   // Bus stimulus
   task automatic step();
      @(posedge nw);
      #2;                                          // Drive just after the edge
   endtask

   task automatic idle(input int n);
      repeat (n) step();
   endtask

   task automatic write_reg(input logic [7:0] ofs, input logic [15:0] data, input logic sel);
      io_sel = sel;
      addr   = ofs;
      wdata  = data;
      wr_stb = 1'b1;
      step();
      wr_stb = 1'b0;
      io_sel = 1'b1;
   endtask

   task automatic read_reg(input logic [7:0] ofs, input logic sel);
      io_sel = sel;
      addr   = ofs;
      rd_stb = 1'b1;
      step();
      rd_stb = 1'b0;
      io_sel = 1'b1;
   endtask

   task automatic read_span(input int lo, input int hi);
      int i;
      for (i = lo; i <= hi; i++) begin             // One read per cycle
         addr   = 8'(i);
         rd_stb = 1'b1;
         step();
      end
      rd_stb = 1'b0;
   endtask

   task automatic wait_ws_low(input int limit);
      int n;
      n = 0;
      while (ws && (n < limit)) begin
         step();
         n++;
      end
      if (ws)
         stop_run("timed out waiting for the wait state to end");
   endtask

   task automatic wait_irq(input int limit, output int waited);
      waited = 0;
      while (!irq && (waited < limit)) begin
         step();
         waited++;
      end
      if (!irq)
         stop_run("timed out waiting for the timer interrupt");
   endtask

   initial begin
      logic [15:0] a_op;
      logic [15:0] b_op;
      int          waited;
      void'($urandom(63599));
      arst_n = 1'b0;
      io_sel = 1'b0;
      addr   = 8'h00;
      wdata  = 16'h0000;
      wr_stb = 1'b0;
      rd_stb = 1'b0;
      repeat (5) @(posedge nw);
      #2;
      arst_n = 1'b1;
      io_sel = 1'b1;

      // Reset state, empty product reads zero with skip
      assert (!rd_valid && !skip && !ws && !irq)
         else value_error("outputs not idle after reset");
      read_reg(card_pkg::OFS_PORT_A, 1'b1);
      idle(3);

      // Multiplier with random operands, then a forced zero
      repeat (6) begin
         a_op = 16'($urandom);
         b_op = 16'($urandom);
         write_reg(card_pkg::OFS_PORT_A, a_op, 1'b1);
         write_reg(card_pkg::OFS_PORT_B, b_op, 1'b1);
         idle(1);
         read_reg(card_pkg::OFS_PORT_A, 1'b1);
         read_reg(card_pkg::OFS_PORT_B, 1'b1);
      end
      write_reg(card_pkg::OFS_PORT_B, 16'h0000, 1'b1);
      idle(1);
      read_reg(card_pkg::OFS_PORT_B, 1'b1);
      read_reg(card_pkg::OFS_PORT_A, 1'b1);
      idle(3);

      // Zero span and constants back to back
      read_span('hf1, 'hfc);
      idle(3);

      // Wait state on F0, write under ws is dropped
      write_reg(card_pkg::OFS_PORT_A, 16'h0003, 1'b1);
      write_reg(card_pkg::OFS_PORT_B, 16'h0005, 1'b1);
      idle(1);
      read_reg(card_pkg::OFS_WAIT, 1'b1);
      write_reg(card_pkg::OFS_PORT_A, 16'hffff, 1'b1);
      wait_ws_low(2 * card_pkg::WS_CYCLES);
      idle(1);
      read_reg(card_pkg::OFS_PORT_A, 1'b1);
      idle(2);
      write_reg(card_pkg::OFS_WAIT, 16'h00aa, 1'b1);
      wait_ws_low(2 * card_pkg::WS_CYCLES);
      idle(2);

      // Timer, live count then a full expiry
      write_reg(card_pkg::OFS_TIMER, 16'd5, 1'b1);
      idle(9);
      read_reg(card_pkg::OFS_TIMER, 1'b1);
      idle(2);
      write_reg(card_pkg::OFS_TIMER, 16'd3, 1'b1);
      wait_irq(3 * card_pkg::TICK_DIV + 10, waited);
      assert (waited >= 3 * card_pkg::TICK_DIV)
         else value_error($sformatf("irq after %0d cycles, too early", waited));
      read_reg(card_pkg::OFS_TIMER, 1'b1);
      idle(2);
      write_reg(card_pkg::OFS_TIMER, 16'd0, 1'b1);
      idle(4 * card_pkg::TICK_DIV);
      assert (!irq)
         else value_error("irq high after the timer was stopped");

      // Accesses outside the card page
      read_reg(card_pkg::OFS_PORT_A, 1'b0);
      write_reg(card_pkg::OFS_PORT_A, 16'h1111, 1'b0);
      write_reg(8'hed, 16'h2222, 1'b1);
      read_reg(8'hef, 1'b1);
      read_reg(8'h00, 1'b1);
      idle(2);
      read_reg(card_pkg::OFS_PORT_A, 1'b1);
      idle(3);

      $display("PASS: all tests");
      $finish;
   end

endmodule

//--- wait_state_gen.sv
//////////////////////////////////////////////////
// Wait-state generator
// Holds ws for a fixed count, then strobes done
//////////////////////////////////////////////////

`timescale 1ns/1ns

module wait_state_gen (
   input  logic nw,                                // Card clock
   input  logic arst_n,                            // Async reset, active low
   input  logic ws_start,                          // Access to F0 accepted
   output logic ws,                                // Wait level
   output logic ws_done                            // Last wait cycle
);

   logic [card_pkg::WS_W-1:0] ws_cnt;              // Remaining wait cycles

   //////////////////////////////////////////////////
   // Down-counter
   always_ff @(posedge nw or negedge arst_n) begin
      if (!arst_n) begin
         ws_cnt <= '0;
      end else if (ws_start) begin
         ws_cnt <= card_pkg::WS_W'(card_pkg::WS_CYCLES); // Start a full wait
      end else if (ws_cnt != '0) begin
         ws_cnt <= ws_cnt - 1'b1;                  // Count towards idle
      end
   end

   assign ws = (ws_cnt != '0);                     // High while counting

   // Sampled on the edge where ws drops
   assign ws_done = (ws_cnt == card_pkg::WS_W'(1));

endmodule
